// File: src/cc_pkg.sv
// Shared widths, opcodes and offload structs for the core complex.
// Opcode values follow the IPU decode; every code not listed is illegal.

package cc_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned IdWidth   = 5;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned OpWidth   = 4;

  // Response sources at the arbiter: multiplier, divider, illegal
  localparam int unsigned NumRespSrc = 3;
  localparam int unsigned PtrWidth   = $clog2(NumRespSrc);

  // Divider step counter covers setup plus one step per bit
  localparam int unsigned DivCntWidth = $clog2(DataWidth) + 1;

  // ------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------
  typedef enum logic [OpWidth-1:0] {
    MUL    = 4'd0,
    MULH   = 4'd1,
    MULHSU = 4'd2,
    MULHU  = 4'd3,
    DIV    = 4'd4,
    DIVU   = 4'd5,
    REM    = 4'd6,
    REMU   = 4'd7
  } ipu_op_e;

  // ------------------------------------------------------------
  // Offload structs
  // ------------------------------------------------------------
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    ipu_op_e              op;
    logic [DataWidth-1:0] arga;
    logic [DataWidth-1:0] argb;
  } acc_req_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } acc_resp_t;

endpackage

// File: src/acc_if.sv
// Valid/ready channel between IPU blocks; payload type set per instance.
// Payload and valid must stay stable until ready is seen high.

`timescale 1ns/1ps

interface acc_if #(
  parameter type T = logic
) ();

  logic valid;
  logic ready;
  T     payload;

  // Producer side
  modport src (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: src/spill_register.sv
// Two-entry cut register on a valid/ready path, answers in order.
// With Bypass set it is plain wires and adds no latency.

`timescale 1ns/1ps

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_spill
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;
    T     a_data_q, b_data_q;

    // Slot A takes new data, slot B holds the older entry on a stall
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Stalled output must not change under the consumer
    a_hold_stable: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (valid_o && !ready_i) |=> (valid_o && $stable(data_o))
    ) else $error("spill_register: output changed while stalled");
  end

endmodule

// File: src/ipu_multiplier.sv
// Two-stage 32x32 multiplier, low or high product per opcode.
// Holds two operations; the pipe stalls as a whole when the output is blocked.

`timescale 1ns/1ps

module ipu_multiplier (
  input  logic clk_i,
  input  logic rst_i,
  acc_if.dst   req,
  acc_if.src   resp
);

  logic                               advance;
  logic                               a_signed, b_signed;
  logic                               s1_valid_q, s2_valid_q;
  logic                               s1_high_q;
  logic signed [cc_pkg::DataWidth:0]  s1_a_q, s1_b_q;
  logic [cc_pkg::IdWidth-1:0]         s1_id_q, s2_id_q;
  logic [cc_pkg::DataWidth-1:0]       s2_data_q;
  logic signed [2*cc_pkg::DataWidth-1:0] prod;

  // Move forward whenever the output slot is free or leaving
  assign advance   = !s2_valid_q || resp.ready;
  assign req.ready = advance;

  // Operand signedness per RISC-V M
  always_comb begin
    a_signed = (req.payload.op == cc_pkg::MULH) || (req.payload.op == cc_pkg::MULHSU);
    b_signed = (req.payload.op == cc_pkg::MULH);
  end

  // 33-bit signed operands widened to the 64-bit product
  assign prod = (2*cc_pkg::DataWidth)'(s1_a_q) * (2*cc_pkg::DataWidth)'(s1_b_q);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= req.valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_id_q   <= req.payload.id;
      s1_high_q <= (req.payload.op != cc_pkg::MUL);
      s1_a_q    <= {a_signed && req.payload.arga[cc_pkg::DataWidth-1], req.payload.arga};
      s1_b_q    <= {b_signed && req.payload.argb[cc_pkg::DataWidth-1], req.payload.argb};
      s2_id_q   <= s1_id_q;
      if (s1_high_q) begin
        s2_data_q <= prod[2*cc_pkg::DataWidth-1:cc_pkg::DataWidth];
      end else begin
        s2_data_q <= prod[cc_pkg::DataWidth-1:0];
      end
    end
  end

  assign resp.valid         = s2_valid_q;
  assign resp.payload.id    = s2_id_q;
  assign resp.payload.data  = s2_data_q;
  assign resp.payload.error = 1'b0;

endmodule

// File: src/ipu_divider.sv
// Bit-serial restoring divider for DIV/DIVU/REM/REMU, one operation at a time.
// 34 cycles to result: setup, 32 steps, sign fix. Divide by zero per RISC-V.

`timescale 1ns/1ps

module ipu_divider (
  input  logic clk_i,
  input  logic rst_i,
  acc_if.dst   req,
  acc_if.src   resp
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FIX,
    DONE
  } div_state_e;

  div_state_e                       state_q;
  logic [cc_pkg::DivCntWidth-1:0]   cnt_q;
  logic [cc_pkg::IdWidth-1:0]       id_q;
  logic                             is_rem_q, is_signed_q;
  logic                             neg_quo_q, neg_rem_q;
  logic [cc_pkg::DataWidth-1:0]     quo_q, dvs_q, rem_q;
  logic [cc_pkg::DataWidth:0]       shifted;
  logic [cc_pkg::DataWidth+1:0]     diff;

  assign req.ready = (state_q == IDLE);

  // One restoring step: shift in next dividend bit, try to subtract
  assign shifted = {rem_q, quo_q[cc_pkg::DataWidth-1]};
  assign diff    = {1'b0, shifted} - {2'b00, dvs_q};

  // ------------------------------------------------------------
  // Sequencer
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req.valid) begin
            state_q <= RUN;
            cnt_q   <= '0;
          end
        end
        RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == cc_pkg::DivCntWidth'(cc_pkg::DataWidth)) begin
            state_q <= FIX;
          end
        end
        FIX: state_q <= DONE;
        DONE: begin
          if (resp.ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (req.valid) begin
          id_q        <= req.payload.id;
          is_rem_q    <= (req.payload.op == cc_pkg::REM) || (req.payload.op == cc_pkg::REMU);
          is_signed_q <= (req.payload.op == cc_pkg::DIV) || (req.payload.op == cc_pkg::REM);
          quo_q       <= req.payload.arga;
          dvs_q       <= req.payload.argb;
        end
      end
      RUN: begin
        if (cnt_q == '0) begin
          // Setup: magnitudes and result signs
          neg_rem_q <= is_signed_q && quo_q[cc_pkg::DataWidth-1];
          // Zero divisor keeps the all-ones quotient unsigned
          neg_quo_q <= is_signed_q && (dvs_q != '0)
                       && (quo_q[cc_pkg::DataWidth-1] ^ dvs_q[cc_pkg::DataWidth-1]);
          quo_q     <= (is_signed_q && quo_q[cc_pkg::DataWidth-1]) ? -quo_q : quo_q;
          dvs_q     <= (is_signed_q && dvs_q[cc_pkg::DataWidth-1]) ? -dvs_q : dvs_q;
          rem_q     <= '0;
        end else begin
          quo_q <= {quo_q[cc_pkg::DataWidth-2:0], !diff[cc_pkg::DataWidth+1]};
          rem_q <= diff[cc_pkg::DataWidth+1] ? shifted[cc_pkg::DataWidth-1:0]
                                             : diff[cc_pkg::DataWidth-1:0];
        end
      end
      FIX: begin
        // Result lands in quo_q for the response
        if (is_rem_q) begin
          quo_q <= neg_rem_q ? -rem_q : rem_q;
        end else begin
          quo_q <= neg_quo_q ? -quo_q : quo_q;
        end
      end
      default: ;
    endcase
  end

  assign resp.valid         = (state_q == DONE);
  assign resp.payload.id    = id_q;
  assign resp.payload.data  = quo_q;
  assign resp.payload.error = 1'b0;

  // An accepted operation blocks new requests for its full run
  a_busy_no_ready: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (req.valid && req.ready) |=> (!req.ready) [*34]
  ) else $error("ipu_divider: request accepted while busy");

endmodule

// File: src/ipu_resp_arbiter.sv
// Round-robin merge of the IPU response sources onto one port.
// Combinational grant; priority moves past the winner after each transfer.

`timescale 1ns/1ps

module ipu_resp_arbiter (
  input  logic              clk_i,
  input  logic              rst_i,
  acc_if.dst                src [cc_pkg::NumRespSrc],
  output logic              dst_valid_o,
  input  logic              dst_ready_i,
  output cc_pkg::acc_resp_t dst_o
);

  logic [cc_pkg::NumRespSrc-1:0] valid, grant;
  cc_pkg::acc_resp_t             payload [cc_pkg::NumRespSrc];
  logic [cc_pkg::PtrWidth-1:0]   ptr_q, grant_idx;

  for (genvar i = 0; i < cc_pkg::NumRespSrc; i++) begin : g_src
    assign valid[i]     = src[i].valid;
    assign payload[i]   = src[i].payload;
    // Only the winner sees ready
    assign src[i].ready = grant[i] && dst_ready_i;
  end

  // First valid source at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    grant     = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int unsigned i = 0; i < cc_pkg::NumRespSrc; i++) begin
      idx = (int'(ptr_q) + i) % cc_pkg::NumRespSrc;
      if (!found && valid[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = cc_pkg::PtrWidth'(idx);
      end
    end
  end

  assign dst_valid_o = |valid;
  assign dst_o       = payload[grant_idx];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (dst_valid_o && dst_ready_i) begin
      if (grant_idx == cc_pkg::PtrWidth'(cc_pkg::NumRespSrc - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_idx + 1'b1;
      end
    end
  end

  // One winner per cycle, never the previous one while another source waits
  a_grant_rotate: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (dst_valid_o && dst_ready_i) |=>
      ($onehot0(grant)
       && (((valid & ~$past(grant)) == '0) || ((grant & $past(grant)) == '0)))
  ) else $error("ipu_resp_arbiter: grant not one-hot or priority did not rotate");

endmodule

// File: src/ipu.sv
// Integer processing unit: multiply, divide and an illegal-op responder.
// Responses carry the request id and may return out of order.

`timescale 1ns/1ps

module ipu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  cc_pkg::acc_req_t  req_i,
  output logic              resp_valid_o,
  input  logic              resp_ready_i,
  output cc_pkg::acc_resp_t resp_o
);

  acc_if #(.T(cc_pkg::acc_req_t))  mul_req ();
  acc_if #(.T(cc_pkg::acc_req_t))  div_req ();
  // Source 0 multiplier, 1 divider, 2 illegal responder
  acc_if #(.T(cc_pkg::acc_resp_t)) unit_resp [cc_pkg::NumRespSrc] ();

  logic                       sel_mul, sel_div;
  logic                       ill_ready, ill_accept, ill_valid_q;
  logic [cc_pkg::IdWidth-1:0] ill_id_q;

  // Opcode decode
  always_comb begin
    sel_mul = 1'b0;
    sel_div = 1'b0;
    case (req_i.op)
      cc_pkg::MUL, cc_pkg::MULH, cc_pkg::MULHSU, cc_pkg::MULHU: sel_mul = 1'b1;
      cc_pkg::DIV, cc_pkg::DIVU, cc_pkg::REM, cc_pkg::REMU:     sel_div = 1'b1;
      default: ;
    endcase
  end

  assign mul_req.valid   = req_valid_i && sel_mul;
  assign mul_req.payload = req_i;
  assign div_req.valid   = req_valid_i && sel_div;
  assign div_req.payload = req_i;

  assign req_ready_o = sel_mul ? mul_req.ready :
                       sel_div ? div_req.ready : ill_ready;

  // ------------------------------------------------------------
  // Illegal opcode responder
  // ------------------------------------------------------------
  assign ill_ready  = !ill_valid_q || unit_resp[2].ready;
  assign ill_accept = req_valid_i && !sel_mul && !sel_div && ill_ready;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ill_valid_q <= 1'b0;
    end else if (ill_accept) begin
      ill_valid_q <= 1'b1;
    end else if (unit_resp[2].ready) begin
      ill_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ill_accept) begin
      ill_id_q <= req_i.id;
    end
  end

  assign unit_resp[2].valid         = ill_valid_q;
  assign unit_resp[2].payload.id    = ill_id_q;
  assign unit_resp[2].payload.data  = '0;
  assign unit_resp[2].payload.error = 1'b1;

  ipu_multiplier i_multiplier (
    .clk_i ( clk_i        ),
    .rst_i ( rst_i        ),
    .req   ( mul_req      ),
    .resp  ( unit_resp[0] )
  );

  ipu_divider i_divider (
    .clk_i ( clk_i        ),
    .rst_i ( rst_i        ),
    .req   ( div_req      ),
    .resp  ( unit_resp[1] )
  );

  ipu_resp_arbiter i_resp_arbiter (
    .clk_i       ( clk_i        ),
    .rst_i       ( rst_i        ),
    .src         ( unit_resp    ),
    .dst_valid_o ( resp_valid_o ),
    .dst_ready_i ( resp_ready_i ),
    .dst_o       ( resp_o       )
  );

endmodule

// File: src/core_complex.sv
// Offload side of the core complex: request cut, IPU, response cut.
// Responses are matched by id; order may differ from issue order.

`timescale 1ns/1ps

module core_complex #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Offload request
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  logic [cc_pkg::IdWidth-1:0]   req_id_i,
  input  logic [cc_pkg::OpWidth-1:0]   req_op_i,
  input  logic [cc_pkg::DataWidth-1:0] req_arga_i,
  input  logic [cc_pkg::DataWidth-1:0] req_argb_i,
  // Offload response
  output logic                         resp_valid_o,
  input  logic                         resp_ready_i,
  output logic [cc_pkg::IdWidth-1:0]   resp_id_o,
  output logic [cc_pkg::DataWidth-1:0] resp_data_o,
  output logic                         resp_error_o
);

  cc_pkg::acc_req_t  req_d, req_q;
  cc_pkg::acc_resp_t resp_d, resp_q;
  logic              req_q_valid, req_q_ready;
  logic              resp_d_valid, resp_d_ready;

  assign req_d.id   = req_id_i;
  assign req_d.op   = cc_pkg::ipu_op_e'(req_op_i);
  assign req_d.arga = req_arga_i;
  assign req_d.argb = req_argb_i;

  spill_register #(
    .T      ( cc_pkg::acc_req_t   ),
    .Bypass ( !RegisterOffloadReq )
  ) i_spill_req (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_d       ),
    .valid_o ( req_q_valid ),
    .ready_i ( req_q_ready ),
    .data_o  ( req_q       )
  );

  ipu i_ipu (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_valid_i  ( req_q_valid  ),
    .req_ready_o  ( req_q_ready  ),
    .req_i        ( req_q        ),
    .resp_valid_o ( resp_d_valid ),
    .resp_ready_i ( resp_d_ready ),
    .resp_o       ( resp_d       )
  );

  spill_register #(
    .T      ( cc_pkg::acc_resp_t   ),
    .Bypass ( !RegisterOffloadResp )
  ) i_spill_resp (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( resp_d_valid ),
    .ready_o ( resp_d_ready ),
    .data_i  ( resp_d       ),
    .valid_o ( resp_valid_o ),
    .ready_i ( resp_ready_i ),
    .data_o  ( resp_q       )
  );

  assign resp_id_o    = resp_q.id;
  assign resp_data_o  = resp_q.data;
  assign resp_error_o = resp_q.error;

endmodule

// File: tests/tb_core_complex.sv
// Directed testbench for the offload core complex with both cut registers on.
// Expected results follow the RISC-V M rules; responses are matched by id.

`timescale 1ns/1ps

module tb_core_complex;

  localparam int ClkPeriod    = 10;
  localparam int CyclesPerReq = 40;
  // Requests per test: multiply, divide, out of order, illegal, back-pressure
  localparam int ReqTotal     = 52 + 28 + 6 + 3 + 8;
  localparam int AcceptLimit  = 200;
  localparam int BurstLen     = 8;

  logic                         clk_i = 1'b0;
  logic                         rst_i;
  logic                         req_valid_i;
  logic                         req_ready_o;
  logic [cc_pkg::IdWidth-1:0]   req_id_i;
  logic [cc_pkg::OpWidth-1:0]   req_op_i;
  logic [cc_pkg::DataWidth-1:0] req_arga_i;
  logic [cc_pkg::DataWidth-1:0] req_argb_i;
  logic                         resp_valid_o;
  logic                         resp_ready_i;
  logic [cc_pkg::IdWidth-1:0]   resp_id_o;
  logic [cc_pkg::DataWidth-1:0] resp_data_o;
  logic                         resp_error_o;

  // Scoreboard indexed by id
  logic [31:0] pending;
  logic [31:0] exp_data [32];
  logic        exp_err  [32];
  int          arr_at   [32];
  int          arr_seq = 0;

  int    seed = 83503;
  int    err_count = 0;
  int    err_mark = 0;
  int    check_count = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string cur_test = "none";

  always #(ClkPeriod / 2) clk_i = !clk_i;

  core_complex #(
    .RegisterOffloadReq  ( 1'b1 ),
    .RegisterOffloadResp ( 1'b1 )
  ) core_complex_inst (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .req_id_i     ( req_id_i     ),
    .req_op_i     ( req_op_i     ),
    .req_arga_i   ( req_arga_i   ),
    .req_argb_i   ( req_argb_i   ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_id_o    ( resp_id_o    ),
    .resp_data_o  ( resp_data_o  ),
    .resp_error_o ( resp_error_o )
  );

  // ------------------------------------------------------------
  // Reference model and checker
  // ------------------------------------------------------------
  // Returns {error, data}
  function automatic logic [32:0] ref_result(input logic [3:0] op,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [63:0] sp;
    logic [63:0]        up;
    logic [31:0]        r;
    logic               bad;
    sp  = '0;
    up  = '0;
    r   = '0;
    bad = 1'b0;
    case (op)
      cc_pkg::MUL: begin
        up = {32'b0, a} * {32'b0, b};
        r  = up[31:0];
      end
      cc_pkg::MULH: begin
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        r  = sp[63:32];
      end
      cc_pkg::MULHSU: begin
        sp = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
        r  = sp[63:32];
      end
      cc_pkg::MULHU: begin
        up = {32'b0, a} * {32'b0, b};
        r  = up[63:32];
      end
      cc_pkg::DIV: begin
        if (b == 32'd0) r = 32'hffff_ffff;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff) r = a;
        else r = $signed(a) / $signed(b);
      end
      cc_pkg::DIVU: begin
        if (b == 32'd0) r = 32'hffff_ffff;
        else r = a / b;
      end
      cc_pkg::REM: begin
        if (b == 32'd0) r = a;
        else if (a == 32'h8000_0000 && b == 32'hffff_ffff) r = 32'd0;
        else r = $signed(a) % $signed(b);
      end
      cc_pkg::REMU: begin
        if (b == 32'd0) r = a;
        else r = a % b;
      end
      default: bad = 1'b1;
    endcase
    return {bad, r};
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  // Transfers are sampled mid-cycle where handshake signals are settled
  always @(negedge clk_i) begin
    if (!rst_i && resp_valid_o && resp_ready_i) begin
      if (!pending[resp_id_o]) begin
        $display("test %s: response with id %0d was not expected or came twice",
                 cur_test, resp_id_o);
        err_count++;
      end else begin
        compare(cur_test, exp_data[resp_id_o], resp_data_o);
        compare(cur_test, {31'b0, exp_err[resp_id_o]}, {31'b0, resp_error_o});
        pending[resp_id_o] = 1'b0;
        arr_at[resp_id_o]  = arr_seq;
        arr_seq++;
      end
    end
  end

  // ------------------------------------------------------------
  // Request driving
  // ------------------------------------------------------------
  task automatic present_req(input logic [4:0] id, input logic [3:0] op,
                             input logic [31:0] a, input logic [31:0] b);
    req_valid_i = 1'b1;
    req_id_i    = id;
    req_op_i    = op;
    req_arga_i  = a;
    req_argb_i  = b;
    {exp_err[id], exp_data[id]} = ref_result(op, a, b);
    pending[id] = 1'b1;
  endtask

  task automatic await_accept();
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < AcceptLimit) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
    end
    req_valid_i = 1'b0;
    if (!taken) begin
      $display("test %s: request id %0d was never accepted", cur_test, req_id_i);
      err_count++;
      pending[req_id_i] = 1'b0;
    end
  endtask

  task automatic send_req(input logic [4:0] id, input logic [3:0] op,
                          input logic [31:0] a, input logic [31:0] b);
    present_req(id, op, a, b);
    await_accept();
  endtask

  task automatic await_responses();
    int waited;
    int limit;
    waited = 0;
    limit  = ($countones(pending) + 1) * CyclesPerReq;
    while (pending != '0 && waited < limit) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (pending != '0) begin
      $display("test %s: %0d responses never arrived", cur_test, $countones(pending));
      err_count++;
      pending = '0;
    end
  endtask

  task automatic open_test(input string name);
    cur_test = name;
    err_mark = err_count;
    tests_run++;
  endtask

  task automatic close_test();
    await_responses();
    if (err_count == err_mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, err_count - err_mark);
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic reset_state();
    open_test("reset_state");
    @(negedge clk_i);
    compare(cur_test, 32'd0, {31'b0, resp_valid_o});
    compare(cur_test, 32'd1, {31'b0, req_ready_o});
    @(posedge clk_i);
    #1;
    close_test();
  endtask

  task automatic multiply_ops();
    logic [31:0] corner [3];
    logic [3:0]  ops [4];
    logic [4:0]  id;
    corner[0] = 32'h0000_0000;
    corner[1] = 32'hffff_ffff;
    corner[2] = 32'h8000_0000;
    ops[0] = cc_pkg::MUL;
    ops[1] = cc_pkg::MULH;
    ops[2] = cc_pkg::MULHSU;
    ops[3] = cc_pkg::MULHU;
    open_test("multiply");
    for (int o = 0; o < 4; o++) begin
      id = '0;
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          send_req(id, ops[o], corner[i], corner[j]);
          id++;
        end
      end
      for (int k = 0; k < 4; k++) begin
        send_req(id, ops[o], $random(seed), $random(seed));
        id++;
      end
      await_responses();
    end
    close_test();
  endtask

  task automatic divide_ops();
    logic [3:0] ops [4];
    logic [4:0] id;
    ops[0] = cc_pkg::DIV;
    ops[1] = cc_pkg::DIVU;
    ops[2] = cc_pkg::REM;
    ops[3] = cc_pkg::REMU;
    open_test("divide");
    for (int o = 0; o < 4; o++) begin
      id = '0;
      for (int k = 0; k < 4; k++) begin
        send_req(id, ops[o], $random(seed), $random(seed));
        id++;
      end
      // Divide by zero, then signed overflow
      send_req(id, ops[o], $random(seed), 32'd0);
      send_req(id + 5'd1, ops[o], 32'h8000_0000, 32'd0);
      send_req(id + 5'd2, ops[o], 32'h8000_0000, 32'hffff_ffff);
      await_responses();
    end
    close_test();
  endtask

  task automatic out_of_order();
    open_test("out_of_order");
    send_req(5'd1, cc_pkg::DIV, 32'hffff_f000, 32'd7);
    for (int i = 2; i < 7; i++) begin
      send_req(5'(i), cc_pkg::MUL, $random(seed), $random(seed));
    end
    await_responses();
    // The long divide must finish after the last multiply
    compare(cur_test, 32'd1, {31'b0, arr_at[1] > arr_at[6]});
    close_test();
  endtask

  task automatic illegal_op();
    open_test("illegal_op");
    send_req(5'd9, 4'd8, $random(seed), $random(seed));
    send_req(5'd10, 4'd12, $random(seed), $random(seed));
    send_req(5'd11, 4'd15, $random(seed), $random(seed));
    close_test();
  endtask

  task automatic back_pressure();
    int   sent;
    int   cyc;
    logic taken;
    logic stalled;
    sent    = 0;
    cyc     = 0;
    stalled = 1'b0;
    open_test("back_pressure");
    resp_ready_i = 1'b0;
    present_req(5'd16, cc_pkg::MULHU, $random(seed), $random(seed));
    while (cyc < 50) begin
      @(negedge clk_i);
      taken = req_ready_o;
      if (req_valid_i && !taken) stalled = 1'b1;
      @(posedge clk_i);
      #1;
      cyc++;
      if (req_valid_i && taken) begin
        sent++;
        if (sent < BurstLen) begin
          present_req(5'(16 + sent), cc_pkg::MULHU, $random(seed), $random(seed));
        end else begin
          req_valid_i = 1'b0;
        end
      end
    end
    compare(cur_test, 32'd1, {31'b0, stalled});
    resp_ready_i = 1'b1;
    if (req_valid_i) begin
      await_accept();
      sent++;
    end
    while (sent < BurstLen) begin
      send_req(5'(16 + sent), cc_pkg::MULHU, $random(seed), $random(seed));
      sent++;
    end
    close_test();
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin : main
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_id_i     = '0;
    req_op_i     = '0;
    req_arga_i   = '0;
    req_argb_i   = '0;
    resp_ready_i = 1'b1;
    pending      = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    reset_state();
    multiply_ops();
    divide_ops();
    out_of_order();
    illegal_op();
    back_pressure();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    #(ReqTotal * CyclesPerReq * ClkPeriod);
    $display("watchdog: run did not finish within %0d cycles", ReqTotal * CyclesPerReq);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: sim.f
src/cc_pkg.sv
src/acc_if.sv
src/spill_register.sv
src/ipu_multiplier.sv
src/ipu_divider.sv
src/ipu_resp_arbiter.sv
src/ipu.sv
src/core_complex.sv
tests/tb_core_complex.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core complex testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_core_complex \
  --Mdir obj_dir -o sim_core_complex
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_core_complex)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
  exit 0
fi
exit 1
